// File: design/pad_ctrl_pkg.sv
package pad_ctrl_pkg;

	// Operating modes selected on the two mode pins
	typedef enum logic [1:0] {
		MODE_RESET   = 2'd0,
		MODE_DEBUG   = 2'd1,
		MODE_RUN     = 2'd2,
		MODE_MEMLOAD = 2'd3
	} mode_t;

	// Width of the bidirectional pad ports A and B
	localparam int PAD_WIDTH = 8;

	// One byte as seen on a pad port
	typedef logic [PAD_WIDTH-1:0] pad_byte_t;

	// Pattern-buffer serial address
	localparam int SADDR_WIDTH = 3;

	// Instruction memory geometry
	localparam int IMEM_ADDR_WIDTH = 10;
	localparam int IMEM_DATA_WIDTH = 46;

	// Load clock and write strobe, carried together into the clock domain
	localparam int LOAD_STROBES_WIDTH = 2;

endpackage

// File: design/mode_decoder.sv
`timescale 1ns/100ps

module mode_decoder import pad_ctrl_pkg::*; (
	input  logic [1:0] modesel,
	input  pad_byte_t  io_b_in,
	output logic       debug_mode,
	output logic       reset_pat,
	output logic       reset_patternbuf_low,
	output logic       reset_patternbuf_high,
	output logic       io_b_lsb_oe,
	output logic       io_b_msb_oe,
	output logic       load_clk,
	output logic       load_write
);

	mode_t mode;

	assign mode = mode_t'(modesel);

	always_comb begin
		debug_mode            = 1'b0;
		reset_pat             = 1'b0;
		reset_patternbuf_low  = 1'b0;
		reset_patternbuf_high = 1'b0;
		io_b_lsb_oe           = 1'b0;
		load_clk              = 1'b0;
		load_write            = 1'b0;

		case (mode)
			MODE_RESET: begin
				reset_pat             = 1'b1;
				reset_patternbuf_low  = 1'b1;
				reset_patternbuf_high = 1'b1;
			end
			MODE_DEBUG: begin
				// Resets come in on the low half of port B
				debug_mode            = 1'b1;
				reset_pat             = io_b_in[2];
				reset_patternbuf_low  = io_b_in[0];
				reset_patternbuf_high = io_b_in[1];
			end
			MODE_RUN: begin
				// Core drives the whole of port B
				io_b_lsb_oe = 1'b1;
			end
			MODE_MEMLOAD: begin
				// Everything held in reset while the memory is written
				reset_pat             = 1'b1;
				reset_patternbuf_low  = 1'b1;
				reset_patternbuf_high = 1'b1;
				load_clk              = io_b_in[0];
				load_write            = io_b_in[1];
			end
			default: begin
				reset_pat = 1'b1;
			end
		endcase
	end

	// Upper half of port B is an output in every mode
	assign io_b_msb_oe = 1'b1;

endmodule

// File: design/debug_router.sv
`timescale 1ns/100ps

module debug_router import pad_ctrl_pkg::*; (
	input  logic                   debug_mode,
	input  pad_byte_t              io_a_in,
	input  logic                   sout_low,
	input  logic                   sout_high,
	input  pad_byte_t              core_outputs,
	output logic                   sclk_low,
	output logic                   sclk_high,
	output logic                   ssel_low,
	output logic                   ssel_high,
	output logic                   sin_low,
	output logic                   sin_high,
	output logic [SADDR_WIDTH-1:0] saddr_low,
	output logic [SADDR_WIDTH-1:0] saddr_high,
	output pad_byte_t              io_b_out
);

	// Debug bus fields on port A
	logic                   sclk;
	logic                   ssel;
	logic                   sin;
	logic [SADDR_WIDTH-1:0] saddr;
	logic                   sel_high;
	logic                   sout;

	assign sclk     = io_a_in[0];
	assign ssel     = io_a_in[1];
	assign sin      = io_a_in[2];
	assign saddr    = io_a_in[3 +: SADDR_WIDTH];
	assign sel_high = io_a_in[6];

	// Serial return path from whichever buffer is addressed
	assign sout = sel_high ? sout_high : sout_low;

	always_comb begin
		sclk_low   = 1'b0;
		ssel_low   = 1'b0;
		sin_low    = 1'b0;
		saddr_low  = '0;
		sclk_high  = 1'b0;
		ssel_high  = 1'b0;
		sin_high   = 1'b0;
		saddr_high = '0;

		if (debug_mode) begin
			if (sel_high) begin
				sclk_high  = sclk;
				ssel_high  = ssel;
				sin_high   = sin;
				saddr_high = saddr;
			end else begin
				sclk_low  = sclk;
				ssel_low  = ssel;
				sin_low   = sin;
				saddr_low = saddr;
			end
		end
	end

	always_comb begin
		if (debug_mode) begin
			io_b_out = '0;
			// Bits 0 to 3 act as pull-ups for the reset inputs
			io_b_out[3:0] = 4'hf;
			io_b_out[4]   = sout;
		end else begin
			io_b_out = core_outputs;
		end
	end

endmodule

// File: design/input_synchronizer.sv
`timescale 1ns/100ps

module input_synchronizer import pad_ctrl_pkg::*; #(
	parameter type payload_t = pad_byte_t
) (
	input  logic     clk_int,
	input  logic     rst,
	input  payload_t async_in,
	output payload_t sync_out
);

	// First stage may go metastable, second stage settles it
	payload_t stage_1;
	payload_t stage_2;

	always_ff @(posedge clk_int) begin
		if (rst) begin
			stage_1 <= '0;
			stage_2 <= '0;
		end else begin
			stage_1 <= async_in;
			stage_2 <= stage_1;
		end
	end

	assign sync_out = stage_2;

endmodule

// File: design/imem_loader.sv
`timescale 1ns/100ps

module imem_loader import pad_ctrl_pkg::*; #(
	parameter int ADDR_WIDTH = IMEM_ADDR_WIDTH,
	parameter int DATA_WIDTH = IMEM_DATA_WIDTH
) (
	input  logic                  clk_int,
	input  logic                  rst,
	input  logic                  load_clk,
	input  pad_byte_t             load_byte,
	output logic [ADDR_WIDTH-1:0] imem_write_adr,
	output logic [DATA_WIDTH-1:0] imem_in
);

	localparam int WORD_WIDTH = ADDR_WIDTH + DATA_WIDTH;

	// Address sits above the data word
	// First byte in ends up on top
	logic [WORD_WIDTH-1:0] shifter;
	logic                  load_clk_prev;
	logic                  load_rise;

	assign load_rise = load_clk && !load_clk_prev;

	always_ff @(posedge clk_int) begin
		if (rst) begin
			load_clk_prev <= 1'b0;
			shifter       <= '0;
		end else begin
			load_clk_prev <= load_clk;
			if (load_rise) begin
				shifter <= {shifter[WORD_WIDTH-PAD_WIDTH-1:0], load_byte};
			end
		end
	end

	assign imem_write_adr = shifter[WORD_WIDTH-1 -: ADDR_WIDTH];
	assign imem_in        = shifter[DATA_WIDTH-1:0];

endmodule

// File: design/pad_ctrl.sv
`timescale 1ns/100ps

module pad_ctrl import pad_ctrl_pkg::*; #(
	parameter int DIV_BITS   = 3,
	parameter int ADDR_WIDTH = IMEM_ADDR_WIDTH,
	parameter int DATA_WIDTH = IMEM_DATA_WIDTH
) (
	input  logic                   clk_int,
	input  logic                   rst,

	// Pad inputs
	input  logic [1:0]             modesel,
	input  pad_byte_t              io_a_in,
	input  pad_byte_t              io_b_in,

	// Pattern buffers
	input  logic                   sout_low,
	input  logic                   sout_high,
	output logic                   sclk_low,
	output logic                   sclk_high,
	output logic                   ssel_low,
	output logic                   ssel_high,
	output logic                   sin_low,
	output logic                   sin_high,
	output logic [SADDR_WIDTH-1:0] saddr_low,
	output logic [SADDR_WIDTH-1:0] saddr_high,

	// Resets
	output logic                   reset_pat,
	output logic                   reset_patternbuf_low,
	output logic                   reset_patternbuf_high,

	// Port B drive
	output pad_byte_t              io_b_out,
	output logic                   io_b_lsb_oe,
	output logic                   io_b_msb_oe,

	// Core interface
	input  pad_byte_t              core_outputs,
	output pad_byte_t              data_a,
	output logic                   imem_write,
	output logic [ADDR_WIDTH-1:0]  imem_write_adr,
	output logic [DATA_WIDTH-1:0]  imem_in,

	output logic                   clock_out
);

	typedef logic [LOAD_STROBES_WIDTH-1:0] strobes_t;

	logic     debug_mode;
	logic     load_clk;
	logic     load_write;
	strobes_t load_strobes;
	strobes_t load_strobes_sync;

	logic [DIV_BITS-1:0] div_cnt;

	mode_decoder u_mode_decoder (
		.modesel               (modesel),
		.io_b_in               (io_b_in),
		.debug_mode            (debug_mode),
		.reset_pat             (reset_pat),
		.reset_patternbuf_low  (reset_patternbuf_low),
		.reset_patternbuf_high (reset_patternbuf_high),
		.io_b_lsb_oe           (io_b_lsb_oe),
		.io_b_msb_oe           (io_b_msb_oe),
		.load_clk              (load_clk),
		.load_write            (load_write)
	);

	debug_router u_debug_router (
		.debug_mode   (debug_mode),
		.io_a_in      (io_a_in),
		.sout_low     (sout_low),
		.sout_high    (sout_high),
		.core_outputs (core_outputs),
		.sclk_low     (sclk_low),
		.sclk_high    (sclk_high),
		.ssel_low     (ssel_low),
		.ssel_high    (ssel_high),
		.sin_low      (sin_low),
		.sin_high     (sin_high),
		.saddr_low    (saddr_low),
		.saddr_high   (saddr_high),
		.io_b_out     (io_b_out)
	);

	// Port A arrives asynchronously to clk_int
	input_synchronizer #(
		.payload_t (pad_byte_t)
	) u_sync_port_a (
		.clk_int  (clk_int),
		.rst      (rst),
		.async_in (io_a_in),
		.sync_out (data_a)
	);

	// Bit 0 load clock, bit 1 write strobe
	assign load_strobes = {load_write, load_clk};

	input_synchronizer #(
		.payload_t (strobes_t)
	) u_sync_strobes (
		.clk_int  (clk_int),
		.rst      (rst),
		.async_in (load_strobes),
		.sync_out (load_strobes_sync)
	);

	assign imem_write = load_strobes_sync[1];

	imem_loader #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) u_imem_loader (
		.clk_int        (clk_int),
		.rst            (rst),
		.load_clk       (load_strobes_sync[0]),
		.load_byte      (data_a),
		.imem_write_adr (imem_write_adr),
		.imem_in        (imem_in)
	);

	// Free-running divider
	// Top bit toggles every 2**(DIV_BITS-1) cycles
	always_ff @(posedge clk_int) begin
		if (rst) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign clock_out = div_cnt[DIV_BITS-1];

endmodule

// File: verif/pad_ctrl_tb.sv
`timescale 1ns/100ps

module pad_ctrl_tb import pad_ctrl_pkg::*; ();

	localparam int CLK_PERIOD      = 40;
	localparam int DRIVE_DELAY     = 5;
	localparam int RESET_CYCLES    = 3;
	localparam int PHASE_CYCLES    = 24;
	localparam int LOAD_BYTES      = 7;
	localparam int RUN_STROBES     = 4;
	localparam int WORD_BITS       = IMEM_ADDR_WIDTH + IMEM_DATA_WIDTH;
	localparam int TEST_CYCLES     = 2 * RESET_CYCLES + 4 * (PHASE_CYCLES + 4)
		+ LOAD_BYTES * 7 + RUN_STROBES * 4 + 8;
	localparam int WATCHDOG_MARGIN = 100;

	logic                       clk_int;
	logic                       rst;
	logic [1:0]                 modesel;
	pad_byte_t                  io_a_in;
	pad_byte_t                  io_b_in;
	logic                       sout_low;
	logic                       sout_high;
	pad_byte_t                  core_outputs;
	logic                       sclk_low;
	logic                       sclk_high;
	logic                       ssel_low;
	logic                       ssel_high;
	logic                       sin_low;
	logic                       sin_high;
	logic [SADDR_WIDTH-1:0]     saddr_low;
	logic [SADDR_WIDTH-1:0]     saddr_high;
	logic                       reset_pat;
	logic                       reset_patternbuf_low;
	logic                       reset_patternbuf_high;
	pad_byte_t                  io_b_out;
	logic                       io_b_lsb_oe;
	logic                       io_b_msb_oe;
	pad_byte_t                  data_a;
	logic                       imem_write;
	logic [IMEM_ADDR_WIDTH-1:0] imem_write_adr;
	logic [IMEM_DATA_WIDTH-1:0] imem_in;
	logic                       clock_out;

	integer               seed = 79;
	int                   cycle_cnt;
	logic                 word_check;
	logic [WORD_BITS-1:0] exp_word;
	logic                 load_write_pin;
	pad_byte_t            load_bytes [LOAD_BYTES];

	pad_ctrl #(
		.DIV_BITS   (3),
		.ADDR_WIDTH (IMEM_ADDR_WIDTH),
		.DATA_WIDTH (IMEM_DATA_WIDTH)
	) UUT (
		.clk_int               (clk_int),
		.rst                   (rst),
		.modesel               (modesel),
		.io_a_in               (io_a_in),
		.io_b_in               (io_b_in),
		.sout_low              (sout_low),
		.sout_high             (sout_high),
		.sclk_low              (sclk_low),
		.sclk_high             (sclk_high),
		.ssel_low              (ssel_low),
		.ssel_high             (ssel_high),
		.sin_low               (sin_low),
		.sin_high              (sin_high),
		.saddr_low             (saddr_low),
		.saddr_high            (saddr_high),
		.reset_pat             (reset_pat),
		.reset_patternbuf_low  (reset_patternbuf_low),
		.reset_patternbuf_high (reset_patternbuf_high),
		.io_b_out              (io_b_out),
		.io_b_lsb_oe           (io_b_lsb_oe),
		.io_b_msb_oe           (io_b_msb_oe),
		.core_outputs          (core_outputs),
		.data_a                (data_a),
		.imem_write            (imem_write),
		.imem_write_adr        (imem_write_adr),
		.imem_in               (imem_in),
		.clock_out             (clock_out)
	);

	initial begin
		clk_int = 1'b0;
		forever #(CLK_PERIOD / 2) clk_int = ~clk_int;
	end

	// Edges seen since reset went away
	always @(posedge clk_int) begin
		if (rst) begin
			cycle_cnt <= 0;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	// Write strobe as it should leave the mode gating
	assign load_write_pin = (modesel == MODE_MEMLOAD) && io_b_in[1];

	// Order is reset_pat, low buffer, high buffer
	function automatic logic [2:0] resets_for(logic [1:0] mode, pad_byte_t b);
		case (mode)
			MODE_DEBUG: return {b[2], b[0], b[1]};
			MODE_RUN:   return 3'b000;
			default:    return 3'b111;
		endcase
	endfunction

	// Order is sclk, ssel, sin, saddr
	function automatic logic [5:0] bus_for(logic [1:0] mode, pad_byte_t a, logic high_side);
		if (mode == MODE_DEBUG && a[6] == high_side) begin
			return {a[0], a[1], a[2], a[5:3]};
		end else begin
			return 6'b000000;
		end
	endfunction

	function automatic pad_byte_t port_b_for(logic [1:0] mode, pad_byte_t a, logic sl,
		logic sh, pad_byte_t core);
		if (mode == MODE_DEBUG) begin
			return {3'b000, a[6] ? sh : sl, 4'hf};
		end else begin
			return core;
		end
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopping at the first mismatch");
	endtask

	a_resets: assert property (@(posedge clk_int) disable iff (rst)
		{reset_pat, reset_patternbuf_low, reset_patternbuf_high} == resets_for(modesel, io_b_in))
		else stop_on_error($sformatf("[FAIL] %0t: reset outputs %b in mode %0d",
			$time, {reset_pat, reset_patternbuf_low, reset_patternbuf_high}, modesel));

	a_enables: assert property (@(posedge clk_int) disable iff (rst)
		(io_b_lsb_oe == (modesel == MODE_RUN)) && (io_b_msb_oe == 1'b1))
		else stop_on_error($sformatf("[FAIL] %0t: port B enables %b%b in mode %0d",
			$time, io_b_msb_oe, io_b_lsb_oe, modesel));

	a_route_low: assert property (@(posedge clk_int) disable iff (rst)
		{sclk_low, ssel_low, sin_low, saddr_low} == bus_for(modesel, io_a_in, 1'b0))
		else stop_on_error($sformatf("[FAIL] %0t: low buffer bus wrong, port A %h mode %0d",
			$time, io_a_in, modesel));

	a_route_high: assert property (@(posedge clk_int) disable iff (rst)
		{sclk_high, ssel_high, sin_high, saddr_high} == bus_for(modesel, io_a_in, 1'b1))
		else stop_on_error($sformatf("[FAIL] %0t: high buffer bus wrong, port A %h mode %0d",
			$time, io_a_in, modesel));

	a_port_b: assert property (@(posedge clk_int) disable iff (rst)
		io_b_out == port_b_for(modesel, io_a_in, sout_low, sout_high, core_outputs))
		else stop_on_error($sformatf("[FAIL] %0t: io_b_out %h in mode %0d",
			$time, io_b_out, modesel));

	// Two-edge latency through the synchronisers
	a_data_a: assert property (@(posedge clk_int) disable iff (rst || cycle_cnt < 2)
		data_a == $past(io_a_in, 2))
		else stop_on_error($sformatf("[FAIL] %0t: data_a %h", $time, data_a));

	a_imem_write: assert property (@(posedge clk_int) disable iff (rst || cycle_cnt < 2)
		imem_write == $past(load_write_pin, 2))
		else stop_on_error($sformatf("[FAIL] %0t: imem_write %b", $time, imem_write));

	a_word: assert property (@(posedge clk_int) disable iff (rst || !word_check)
		{imem_write_adr, imem_in} == exp_word)
		else stop_on_error($sformatf("[FAIL] %0t: write word %h, expected %h",
			$time, {imem_write_adr, imem_in}, exp_word));

	// Four cycles low then four high from reset release
	a_clock: assert property (@(posedge clk_int) disable iff (rst)
		clock_out == ((cycle_cnt / 4) % 2 == 1))
		else stop_on_error($sformatf("[FAIL] %0t: clock_out %b after %0d cycles",
			$time, clock_out, cycle_cnt));

	task automatic wait_cycle;
		@(posedge clk_int);
		#DRIVE_DELAY;
	endtask

	task automatic apply_reset;
		rst     = 1'b1;
		modesel = 2'b00;
		io_a_in = '0;
		io_b_in = '0;
		repeat (RESET_CYCLES) wait_cycle;
		rst = 1'b0;
	endtask

	task automatic random_phase(input logic [1:0] mode);
		repeat (PHASE_CYCLES) begin
			modesel      = mode;
			io_a_in      = pad_byte_t'($random(seed));
			io_b_in      = pad_byte_t'($random(seed));
			sout_low     = 1'($random(seed));
			sout_high    = 1'($random(seed));
			core_outputs = pad_byte_t'($random(seed));
			wait_cycle;
		end
		// Quiet gap so no load strobe spills into the next mode
		io_b_in = '0;
		repeat (4) wait_cycle;
	endtask

	task automatic strobe_byte(input pad_byte_t value);
		modesel    = MODE_MEMLOAD;
		io_a_in    = value;
		io_b_in    = pad_byte_t'($random(seed)) & 8'hfe;
		wait_cycle;
		io_b_in[0] = 1'b1;
		repeat (2) wait_cycle;
		io_b_in[0] = 1'b0;
		repeat (4) wait_cycle;
	endtask

	task automatic run_mode_strobes;
		modesel = MODE_RUN;
		repeat (RUN_STROBES) begin
			io_a_in = pad_byte_t'($random(seed));
			io_b_in = pad_byte_t'($random(seed)) | 8'h01;
			repeat (2) wait_cycle;
			io_b_in[0] = 1'b0;
			repeat (2) wait_cycle;
		end
	endtask

	initial begin : stimulus
		int m;
		rst          = 1'b1;
		modesel      = 2'b00;
		io_a_in      = '0;
		io_b_in      = '0;
		sout_low     = 1'b0;
		sout_high    = 1'b0;
		core_outputs = '0;
		word_check   = 1'b0;
		exp_word     = '0;

		apply_reset;
		for (m = 0; m < 4; m++) begin
			random_phase(2'(m));
		end

		// Fresh reset so the write word starts from zero
		apply_reset;
		for (m = 0; m < LOAD_BYTES; m++) begin
			load_bytes[m] = pad_byte_t'($random(seed));
			strobe_byte(load_bytes[m]);
		end

		// First byte loaded is the most significant one
		for (m = 0; m < LOAD_BYTES; m++) begin
			exp_word[WORD_BITS-1-PAD_WIDTH*m -: PAD_WIDTH] = load_bytes[m];
		end
		word_check = 1'b1;
		run_mode_strobes;

		modesel = MODE_RESET;
		io_b_in = '0;
		repeat (8) wait_cycle;

		$display("Simulation passed");
		$finish;
	end

	initial begin : watchdog
		#(CLK_PERIOD * (TEST_CYCLES + WATCHDOG_MARGIN));
		$display("Timeout: the tests did not finish within %0d clock cycles",
			TEST_CYCLES + WATCHDOG_MARGIN);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: files.f
design/pad_ctrl_pkg.sv
design/mode_decoder.sv
design/debug_router.sv
design/input_synchronizer.sv
design/imem_loader.sv
design/pad_ctrl.sv
verif/pad_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the pad_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=pad_ctrl_sim
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module pad_ctrl_tb \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN" \
	-f files.f; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
	exit 0
fi

echo "Pass message not found in $LOG"
exit 1
